// ==== hw/adder_pkg.sv ====
package adder_pkg;

  // default operand width of the unit.
  localparam int DATA_WIDTH = 32;

  // operation codes.
  // bit 0 selects the inverted b operand, bit 1 selects the stored carry as carry-in.
  typedef enum logic [1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_ADC = 2'b10,
    OP_SBC = 2'b11
  } op_e;

endpackage

// ==== hw/operand_if.sv ====
`timescale 1ns/10ps

interface operand_if #(
  parameter int WIDTH = adder_pkg::DATA_WIDTH
);

  // one-cycle strobe for a registered operation.
  logic             valid;
  logic [WIDTH-1:0] a;
  // b as it enters the adder, already inverted for subtraction.
  logic [WIDTH-1:0] b_eff;
  logic             cin;

  modport source (
    output valid,
    output a,
    output b_eff,
    output cin
  );

  modport sink (
    input valid,
    input a,
    input b_eff,
    input cin
  );

endinterface

// ==== hw/operand_stage.sv ====
`timescale 1ns/10ps

module operand_stage #(
  parameter int WIDTH = adder_pkg::DATA_WIDTH
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  adder_pkg::op_e   op,
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             carry_flag,
  operand_if.source        opnd
);

  logic             valid_q;
  adder_pkg::op_e   op_q;
  logic [WIDTH-1:0] a_q;
  logic [WIDTH-1:0] b_q;
  logic             invert_b;

  assign invert_b = (op == adder_pkg::OP_SUB) || (op == adder_pkg::OP_SBC);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      op_q    <= adder_pkg::OP_ADD;
    end else begin
      valid_q <= in_valid;
      if (in_valid) begin
        op_q <= op;
      end
    end
  end

  // operands only move when a new operation is accepted.
  always_ff @(posedge clk) begin
    if (in_valid) begin
      a_q <= a;
      b_q <= invert_b ? ~b : b;
    end
  end

  // carry-in comes from the registered op, so a chained op sees
  // the carry written by its predecessor on the same edge.
  always_comb begin
    case (op_q)
      adder_pkg::OP_ADD: opnd.cin = 1'b0;
      adder_pkg::OP_SUB: opnd.cin = 1'b1;
      adder_pkg::OP_ADC: opnd.cin = carry_flag;
      adder_pkg::OP_SBC: opnd.cin = carry_flag;
      default:           opnd.cin = 1'b0;
    endcase
  end

  assign opnd.valid = valid_q;
  assign opnd.a     = a_q;
  assign opnd.b_eff = b_q;

  // an accepted operation must carry a known code.
  a_op_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> !$isunknown(op)
  );

endmodule

// ==== hw/prefix_adder.sv ====
`timescale 1ns/10ps

module prefix_adder #(
  parameter int WIDTH = adder_pkg::DATA_WIDTH
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  input  logic             cin,
  output logic [WIDTH-1:0] sum,
  output logic             cout,
  output logic             c_top
);

  localparam int LEVELS = $clog2(WIDTH);

  // group generate and propagate per level.
  // level 0 holds the single-bit terms, level LEVELS holds [i:0] for every bit.
  logic [WIDTH-1:0] g_lvl [0:LEVELS];
  logic [WIDTH-1:0] p_lvl [0:LEVELS];

  // bitwise propagate, kept apart for the sum.
  logic [WIDTH-1:0] p_bit;
  // carry out of each bit position, cin included.
  logic [WIDTH-1:0] carry;

  // grey cell, carry only.
  function automatic logic grey_g(
    input logic g_hi,
    input logic p_hi,
    input logic g_lo
  );
    return g_hi | (p_hi & g_lo);
  endfunction

  // black cell, group generate and propagate.
  function automatic logic [1:0] black_gp(
    input logic g_hi,
    input logic p_hi,
    input logic g_lo,
    input logic p_lo
  );
    return {grey_g(g_hi, p_hi, g_lo), p_hi & p_lo};
  endfunction

  if (WIDTH < 4 || (WIDTH & (WIDTH - 1)) != 0) begin : g_width_check
    $error("prefix_adder needs WIDTH to be a power of two of at least 4");
  end

  assign p_bit = a ^ b;

  // cin is folded into bit 0 so the tree yields the final carries directly.
  assign g_lvl[0][0] = (a[0] & b[0]) | (p_bit[0] & cin);
  assign p_lvl[0][0] = p_bit[0];

  for (genvar i = 1; i < WIDTH; i++) begin : g_bit_gp
    assign g_lvl[0][i] = a[i] & b[i];
    assign p_lvl[0][i] = p_bit[i];
  end

  // sklansky-style tree.
  // at level l every bit with bit l set joins the top of the lower half
  // of its 2^(l+1) block; the other half passes through unchanged.
  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    for (genvar i = 0; i < WIDTH; i++) begin : g_node
      localparam int BASE = (i >> (l + 1)) << (l + 1);
      localparam int LO   = BASE + (1 << l) - 1;

      if (((i >> l) & 1) == 0) begin : g_pass
        assign g_lvl[l+1][i] = g_lvl[l][i];
        assign p_lvl[l+1][i] = p_lvl[l][i];
      end else if (BASE == 0) begin : g_grey
        // group reaches bit 0, so only the carry matters from here.
        assign g_lvl[l+1][i] = grey_g(g_lvl[l][i], p_lvl[l][i], g_lvl[l][LO]);
        assign p_lvl[l+1][i] = p_lvl[l][i];
      end else begin : g_black
        assign {g_lvl[l+1][i], p_lvl[l+1][i]} =
          black_gp(g_lvl[l][i], p_lvl[l][i], g_lvl[l][LO], p_lvl[l][LO]);
      end
    end
  end

  assign carry = g_lvl[LEVELS];

  // each sum bit takes the carry from the bit below.
  assign sum[0] = p_bit[0] ^ cin;

  for (genvar i = 1; i < WIDTH; i++) begin : g_sum
    assign sum[i] = p_bit[i] ^ carry[i-1];
  end

  assign cout  = carry[WIDTH-1];
  // carry into the sign bit, for signed overflow.
  assign c_top = carry[WIDTH-2];

endmodule

// ==== hw/result_stage.sv ====
`timescale 1ns/10ps

module result_stage #(
  parameter int WIDTH = adder_pkg::DATA_WIDTH
) (
  input  logic             clk,
  input  logic             rst_n,
  operand_if.sink          opnd,
  input  logic [WIDTH-1:0] sum_next,
  input  logic             cout,
  input  logic             c_top,
  output logic             out_valid,
  output logic [WIDTH-1:0] sum,
  output logic             carry,
  output logic             overflow,
  output logic             zero,
  output logic             negative,
  output logic             carry_flag
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= opnd.valid;
    end
  end

  // result and flags hold until the next valid operation.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum      <= '0;
      carry    <= 1'b0;
      overflow <= 1'b0;
      zero     <= 1'b0;
      negative <= 1'b0;
    end else if (opnd.valid) begin
      sum      <= sum_next;
      carry    <= cout;
      // signed overflow when the carries into and out of the sign bit differ.
      overflow <= cout ^ c_top;
      zero     <= (sum_next == '0);
      negative <= sum_next[WIDTH-1];
    end
  end

  // stored carry for adc and sbc.
  assign carry_flag = carry;

  // a written operation must come out of the adder fully known.
  a_result_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    opnd.valid |-> !$isunknown({sum_next, cout, c_top})
  );

endmodule

// ==== hw/adder_unit.sv ====
`timescale 1ns/10ps

module adder_unit #(
  parameter int WIDTH = adder_pkg::DATA_WIDTH
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  adder_pkg::op_e   op,
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic             out_valid,
  output logic [WIDTH-1:0] sum,
  output logic             carry,
  output logic             overflow,
  output logic             zero,
  output logic             negative
);

  operand_if #(.WIDTH(WIDTH)) opnd ();

  logic [WIDTH-1:0] sum_next;
  logic             cout;
  logic             c_top;
  logic             carry_flag;

  operand_stage #(
    .WIDTH(WIDTH)
  ) u_operand_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .op         (op),
    .a          (a),
    .b          (b),
    .carry_flag (carry_flag),
    .opnd       (opnd.source)
  );

  prefix_adder #(
    .WIDTH(WIDTH)
  ) u_prefix_adder (
    .a     (opnd.a),
    .b     (opnd.b_eff),
    .cin   (opnd.cin),
    .sum   (sum_next),
    .cout  (cout),
    .c_top (c_top)
  );

  result_stage #(
    .WIDTH(WIDTH)
  ) u_result_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .opnd       (opnd.sink),
    .sum_next   (sum_next),
    .cout       (cout),
    .c_top      (c_top),
    .out_valid  (out_valid),
    .sum        (sum),
    .carry      (carry),
    .overflow   (overflow),
    .zero       (zero),
    .negative   (negative),
    .carry_flag (carry_flag)
  );

endmodule

// ==== tb/tb_adder_unit.sv ====
`timescale 1ns/10ps

module tb_adder_unit #(
  parameter int          WIDTH = adder_pkg::DATA_WIDTH,
  parameter logic [31:0] SEED  = 32'hdf3e
);

  localparam int PERIOD       = 40;
  localparam int RESET_CYCLES = 3;
  localparam int NUM_DIRECTED = 16;
  localparam int NUM_RANDOM   = 2000;
  localparam int DRAIN_CYCLES = 4;
  localparam int NUM_OPS      = RESET_CYCLES + NUM_DIRECTED + NUM_RANDOM + DRAIN_CYCLES;
  localparam int WATCHDOG_NS  = (NUM_OPS + 10) * PERIOD;

  localparam logic [WIDTH-1:0] ZERO     = '0;
  localparam logic [WIDTH-1:0] ONE      = {{(WIDTH-1){1'b0}}, 1'b1};
  localparam logic [WIDTH-1:0] ALL_ONES = '1;
  localparam logic [WIDTH-1:0] MAX_POS  = {1'b0, {(WIDTH-1){1'b1}}};
  localparam logic [WIDTH-1:0] MIN_NEG  = {1'b1, {(WIDTH-1){1'b0}}};
  localparam logic [WIDTH-1:0] PATTERN  = {(WIDTH/4){4'h9}};

  typedef struct packed {
    logic [WIDTH-1:0] sum;
    logic             carry;
    logic             overflow;
    logic             zero;
    logic             negative;
  } result_t;

  logic             clk;
  logic             rst_n;
  logic             in_valid;
  adder_pkg::op_e   op;
  logic [WIDTH-1:0] a;
  logic [WIDTH-1:0] b;
  logic             out_valid;
  logic [WIDTH-1:0] sum;
  logic             carry;
  logic             overflow;
  logic             zero;
  logic             negative;

  logic [31:0]      lfsr;
  logic             model_carry;
  logic             seen_valid;
  // results in flight, oldest first.
  result_t          exp_q [$];
  result_t          head;
  logic             head_valid;

  adder_unit #(
    .WIDTH(WIDTH)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .sum       (sum),
    .carry     (carry),
    .overflow  (overflow),
    .zero      (zero),
    .negative  (negative)
  );

  initial clk = 1'b0;
  always #(PERIOD/2) clk = ~clk;

  task automatic fail_now(input string msg);
    $display("Error: %0t ns %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  // galois lfsr, taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [WIDTH-1:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[WIDTH-2:0], lfsr[0]};
      lfsr  = lfsr_step(lfsr);
    end
  endtask

  // wide sum of the effective operands, flags taken from the extra bit and the signs.
  function automatic result_t model_result(
    input adder_pkg::op_e   op_in,
    input logic [WIDTH-1:0] a_in,
    input logic [WIDTH-1:0] b_in,
    input logic             carry_in
  );
    logic [WIDTH-1:0] b_eff;
    logic             cin;
    logic [WIDTH:0]   full;
    result_t          r;
    case (op_in)
      adder_pkg::OP_ADD: begin
        b_eff = b_in;
        cin   = 1'b0;
      end
      adder_pkg::OP_SUB: begin
        b_eff = ~b_in;
        cin   = 1'b1;
      end
      adder_pkg::OP_ADC: begin
        b_eff = b_in;
        cin   = carry_in;
      end
      default: begin
        b_eff = ~b_in;
        cin   = carry_in;
      end
    endcase
    full       = {1'b0, a_in} + {1'b0, b_eff} + {{WIDTH{1'b0}}, cin};
    r.sum      = full[WIDTH-1:0];
    r.carry    = full[WIDTH];
    // same-signed operands giving a result of the other sign.
    r.overflow = (a_in[WIDTH-1] == b_eff[WIDTH-1]) && (r.sum[WIDTH-1] != a_in[WIDTH-1]);
    r.zero     = (r.sum == '0);
    r.negative = r.sum[WIDTH-1];
    return r;
  endfunction

  // one clock slot: retire the result leaving the unit, then drive the next input.
  task automatic issue(
    input logic             valid,
    input adder_pkg::op_e   op_in,
    input logic [WIDTH-1:0] a_in,
    input logic [WIDTH-1:0] b_in
  );
    result_t r;
    @(posedge clk);
    if (out_valid && exp_q.size() > 0) begin
      exp_q.delete(0);
    end
    in_valid <= valid;
    op       <= op_in;
    a        <= a_in;
    b        <= b_in;
    if (valid) begin
      r           = model_result(op_in, a_in, b_in, model_carry);
      model_carry = r.carry;
      seen_valid  = 1'b1;
      exp_q.push_back(r);
    end
    head_valid = (exp_q.size() > 0);
    if (head_valid) begin
      head = exp_q[0];
    end
  endtask

  task automatic directed_cases();
    issue(1'b1, adder_pkg::OP_ADD, ALL_ONES, ONE);
    issue(1'b1, adder_pkg::OP_SUB, ZERO, ONE);
    issue(1'b1, adder_pkg::OP_SUB, MIN_NEG, ONE);
    issue(1'b1, adder_pkg::OP_SUB, PATTERN, PATTERN);
    issue(1'b0, adder_pkg::OP_ADD, ZERO, ZERO);
    // leaves the carry clear so an older carry would show in the chain below.
    issue(1'b1, adder_pkg::OP_ADD, MAX_POS, ONE);
    // two-word addition, high word right behind the low word.
    issue(1'b1, adder_pkg::OP_ADD, ALL_ONES, ALL_ONES);
    issue(1'b1, adder_pkg::OP_ADC, PATTERN, PATTERN);
    // two-word subtraction with a borrow out of the low word.
    issue(1'b1, adder_pkg::OP_SUB, ZERO, ONE);
    issue(1'b1, adder_pkg::OP_SBC, PATTERN, ZERO);
    // carry must survive idle cycles.
    issue(1'b1, adder_pkg::OP_ADD, ALL_ONES, ONE);
    repeat (3) issue(1'b0, adder_pkg::OP_ADD, ZERO, ZERO);
    issue(1'b1, adder_pkg::OP_ADC, ZERO, ZERO);
    issue(1'b1, adder_pkg::OP_SBC, MAX_POS, ALL_ONES);
  endtask

  task automatic random_cases();
    logic [WIDTH-1:0] bits;
    logic [WIDTH-1:0] a_r;
    logic [WIDTH-1:0] b_r;
    adder_pkg::op_e   op_r;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      draw_bits(2, bits);
      op_r = adder_pkg::op_e'(bits[1:0]);
      draw_bits(WIDTH, a_r);
      draw_bits(WIDTH, b_r);
      draw_bits(1, bits);
      issue(bits[0], op_r, a_r, b_r);
    end
  endtask

  initial begin
    lfsr        = SEED;
    model_carry = 1'b0;
    seen_valid  = 1'b0;
    head_valid  = 1'b0;
    head        = '0;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    op          = adder_pkg::OP_ADD;
    a           = '0;
    b           = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    directed_cases();
    random_cases();
    repeat (DRAIN_CYCLES) issue(1'b0, adder_pkg::OP_ADD, ZERO, ZERO);
    if (exp_q.size() != 0) begin
      $display("%0d expected results never came out of the unit", exp_q.size());
      $display("TESTS FAILED");
      $fatal(1, "results missing at the end of the run");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("TESTS FAILED");
    $fatal(1, "timeout, the run did not finish within %0d ns", WATCHDOG_NS);
  end

  // outputs stay cleared until the first operation goes in.
  a_reset_state: assert property (
    @(posedge clk) disable iff (!rst_n)
    !seen_valid |-> (!out_valid && sum == '0 && !carry && !overflow && !zero && !negative)
  ) else fail_now("outputs not cleared before the first operation");

  a_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid == $past(in_valid, 2)
  ) else fail_now($sformatf("out_valid %b, two edges after in_valid %b",
                            $sampled(out_valid), $past(in_valid, 2)));

  a_expected: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> head_valid
  ) else fail_now("out_valid high with no operation pending");

  a_sum: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> sum == head.sum
  ) else fail_now($sformatf("sum %h, expected %h", $sampled(sum), $sampled(head.sum)));

  a_carry: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> carry == head.carry
  ) else fail_now($sformatf("carry %b, expected %b", $sampled(carry), $sampled(head.carry)));

  a_flags: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> {overflow, zero, negative} == {head.overflow, head.zero, head.negative}
  ) else fail_now($sformatf("overflow/zero/negative %b%b%b, expected %b%b%b",
                            $sampled(overflow), $sampled(zero), $sampled(negative),
                            $sampled(head.overflow), $sampled(head.zero),
                            $sampled(head.negative)));

endmodule

// ==== files.f ====
hw/adder_pkg.sv
hw/operand_if.sv
hw/operand_stage.sv
hw/prefix_adder.sv
hw/result_stage.sv
hw/adder_unit.sv
tb/tb_adder_unit.sv

// ==== Makefile ====
# Verilator build for the add/subtract unit testbench.
# The simulation binary exits non-zero when the testbench stops with $fatal.

VERILATOR ?= verilator
TOP       ?= tb_adder_unit
WIDTH     ?= 32
# 57150 is 32'hdf3e.
SEED      ?= 57150
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/10ps

PARAMS = -GWIDTH=$(WIDTH) -GSEED=$(SEED)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(PARAMS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) $(PARAMS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
